// File: src/clkdiv_pkg.sv
// Clock divider shared definitions
package clkdiv_pkg;

    // divisor width, values 0..15
    localparam int DIV_W = 4;

    // divide-by-2 out of reset
    localparam logic [DIV_W-1:0] DIV_RESET = 4'd2;

    // measured period needs one bit of headroom over the divisor
    localparam int PER_W = DIV_W + 1;

    // output clock source
    typedef enum logic [1:0] {
        MODE_BYPASS = 2'd0,    // divisor 0 or 1, input clock passes straight through
        MODE_EVEN   = 2'd1,    // single-edge counter
        MODE_ODD    = 2'd2     // dual-edge counter pair
    } div_mode_e;

    // divisor as seen in the output clock domain, plus its decoded mode
    typedef struct packed {
        div_mode_e        mode;
        logic [DIV_W-1:0] div;
    } div_cfg_t;

    // monitor result, period in input clock cycles
    typedef struct packed {
        logic             valid;     // one-cycle strobe per completed period
        logic [PER_W-1:0] period;
    } div_stat_t;

endpackage

// File: src/clkdiv_ctrl.sv
// Clock divider control
module clkdiv_ctrl (
    input  logic                         clk,          // clock being divided
    input  logic                         resetb,
    input  logic                         div_wr,       // one-cycle write strobe
    input  logic [clkdiv_pkg::DIV_W-1:0] div_value,
    input  logic                         even_clk,     // from the even divider
    input  logic                         odd_clk,      // from the odd divider
    output clkdiv_pkg::div_cfg_t         cfg,
    output logic                         clk_out
);
    import clkdiv_pkg::*;

    logic [DIV_W-1:0] div_reg;     // written divisor, clk domain
    logic [DIV_W-1:0] div_meta;    // first resync stage, clk_out domain
    logic [DIV_W-1:0] div_sync;    // second resync stage, drives everything downstream
    div_mode_e        mode;

    // register side
    // div_value is only looked at while the strobe is up
    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb) begin
            div_reg <= DIV_RESET;
        end else if (div_wr) begin
            div_reg <= div_value;
        end
    end

    // two flops on the divided clock
    // a new value lands on cfg at the second clk_out rising edge
    always_ff @(posedge clk_out or negedge resetb) begin
        if (!resetb) begin
            div_meta <= DIV_RESET;
            div_sync <= DIV_RESET;
        end else begin
            div_meta <= div_reg;
            div_sync <= div_meta;
        end
    end

    // mode decode
    // upper bits all zero means divide by 0 or 1
    always_comb begin
        if (div_sync[DIV_W-1:1] == '0) begin
            mode = MODE_BYPASS;
        end else if (!div_sync[0]) begin
            mode = MODE_EVEN;          // low bit clear
        end else begin
            mode = MODE_ODD;
        end
    end

    assign cfg.mode = mode;
    assign cfg.div  = div_sync;

    // output clock select
    // bypass hands out the raw input clock, so divide-by-1 is a real clock
    // and not a stuck level
    always_comb begin
        case (mode)
            MODE_EVEN: begin
                clk_out = even_clk;
            end
            MODE_ODD: begin
                clk_out = odd_clk;
            end
            default: begin
                clk_out = clk;         // bypass
            end
        endcase
    end

    // note that clk_out also clocks the resync flops above
    // in bypass they run on clk itself, so a later write still gets through
    // while an even or odd path is selected they run at the divided rate,
    // which is where the two-old-period settling delay comes from

endmodule

// File: src/clkdiv_even.sv
// Even divisor counter
module clkdiv_even (
    input  logic                 clk,
    input  logic                 resetb,
    input  clkdiv_pkg::div_cfg_t cfg,
    output logic                 even_clk
);
    import clkdiv_pkg::*;

    logic [DIV_W-2:0] cnt;     // half the divisor fits one bit narrower
    logic [DIV_W-2:0] half;    // reload value of N/2
    logic             run;     // even path selected

    assign half = (DIV_W-1)'(cfg.div >> 1);    // low bit is zero in even mode
    assign run  = (cfg.mode == MODE_EVEN);

    // down-counter from N/2 to 1
    // the output flips each time it hits one, so a full period is N input cycles
    // counting starts at 1 so the first flip follows reset straight away
    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb) begin
            cnt      <= (DIV_W-1)'(1);
            even_clk <= 1'b1;
        end else if (run) begin                // idle path holds and does not switch
            if (cnt == (DIV_W-1)'(1)) begin
                cnt      <= half;
                even_clk <= ~even_clk;
            end else begin
                cnt <= cnt - (DIV_W-1)'(1);
            end
        end
    end

    // a divisor change mid-count just finishes the running count first
    // the new half period is then reloaded at the next terminal count
    // no restart is needed here because both output edges come from the
    // same clock edge, so the duty cycle stays 50% regardless of phase

endmodule

// File: src/clkdiv_odd.sv
// Odd divisor counter pair
module clkdiv_odd (
    input  logic                 clk,
    input  logic                 resetb,
    input  clkdiv_pkg::div_cfg_t cfg,
    output logic                 odd_clk
);
    import clkdiv_pkg::*;

    logic             run;         // odd path selected
    logic [DIV_W-1:0] div_seen;    // divisor one clk cycle ago
    logic             restart;     // one-cycle realign pulse
    logic [DIV_W-1:0] cnt_p;       // rising edge counter
    logic             tog_p;       // rising edge toggle
    logic [DIV_W-1:0] cnt_n;       // falling edge counter
    logic             tog_n;       // falling edge toggle
    logic [DIV_W-1:0] cal;         // falling side start delay in falling edges
    logic [DIV_W-1:0] cal_load;    // (N+1)/2 for odd N

    assign run      = (cfg.mode == MODE_ODD);
    assign cal_load = (cfg.div >> 1) + DIV_W'(1);

    // change detect
    // div_seen follows cfg every cycle, so a switch back into odd mode
    // always looks like a change and realigns the pair
    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb) begin
            div_seen <= DIV_RESET;
            restart  <= 1'b0;
        end else begin
            div_seen <= cfg.div;
            restart  <= run && (cfg.div != div_seen);
        end
    end

    // rising side toggles every N rising edges
    // it sees restart one half cycle after the falling side does
    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb) begin
            cnt_p <= DIV_RESET;
            tog_p <= 1'b1;
        end else if (restart) begin
            cnt_p <= cfg.div;
            tog_p <= 1'b1;
        end else if (run) begin
            if (cnt_p == DIV_W'(1)) begin
                cnt_p <= cfg.div;
                tog_p <= ~tog_p;
            end else begin
                cnt_p <= cnt_p - DIV_W'(1);
            end
        end
    end

    // falling side
    // same counter, but held for (N+1)/2 falling edges after restart
    // so its toggles land N half cycles after the rising side toggles
    always_ff @(negedge clk or negedge resetb) begin
        if (!resetb) begin
            cnt_n <= DIV_RESET;
            tog_n <= 1'b1;
            cal   <= '0;
        end else if (restart) begin
            cnt_n <= cfg.div;
            tog_n <= 1'b1;
            cal   <= cal_load;
        end else if (run) begin
            if (cal != '0) begin
                cal <= cal - DIV_W'(1);    // counter waits out the calibration
            end else if (cnt_n == DIV_W'(1)) begin
                cnt_n <= cfg.div;
                tog_n <= ~tog_n;
            end else begin
                cnt_n <= cnt_n - DIV_W'(1);
            end
        end
    end

    // both toggles start at 1, so the output sits low until the rising side flips
    // high and low then each last N half periods of clk
    assign odd_clk = tog_p ^ tog_n;

endmodule

// File: src/clkdiv_monitor.sv
// Output frequency monitor
module clkdiv_monitor (
    input  logic                  clk,
    input  logic                  resetb,
    input  logic                  clk_out,     // divided clock, sampled as data
    output clkdiv_pkg::div_stat_t stat
);
    import clkdiv_pkg::*;

    logic             out_s;       // clk_out seen on clk
    logic             out_d;       // previous sample
    logic             rise;
    logic             armed;       // set once the first, partial period is gone
    logic [PER_W-1:0] cnt;         // clk cycles since the last rise
    logic             valid;
    logic [PER_W-1:0] period;

    // clk_out comes from clk itself, so one flop is enough here
    // in bypass the samples never change and nothing is reported
    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb) begin
            out_s <= 1'b0;
            out_d <= 1'b0;
        end else begin
            out_s <= clk_out;
            out_d <= out_s;
        end
    end

    assign rise = out_s & ~out_d;

    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb) begin
            armed <= 1'b0;
            cnt   <= '0;
            valid <= 1'b0;
        end else begin
            valid <= rise && armed;            // first rise after reset only arms
            if (rise) begin
                armed <= 1'b1;
                cnt   <= PER_W'(1);            // this cycle counts toward the next period
            end else if (cnt != '1) begin
                cnt <= cnt + PER_W'(1);        // saturate if clk_out stops
            end
        end
    end

    // result word, only qualified by valid
    always_ff @(posedge clk) begin
        if (rise && armed) begin
            period <= cnt;
        end
    end

    assign stat.valid  = valid;
    assign stat.period = period;

endmodule

// File: src/clkdiv_top.sv
// Programmable clock divider top
module clkdiv_top (
    input  logic                         clk,
    input  logic                         resetb,
    input  logic                         div_wr,
    input  logic [clkdiv_pkg::DIV_W-1:0] div_value,
    output logic                         clk_out,
    output clkdiv_pkg::div_stat_t        stat
);
    import clkdiv_pkg::*;

    div_cfg_t cfg;         // resynchronized divisor and mode
    logic     even_clk;
    logic     odd_clk;

    // divisor register, resync and output select
    clkdiv_ctrl clkdiv_ctrl_i (
        .clk       (clk),
        .resetb    (resetb),
        .div_wr    (div_wr),
        .div_value (div_value),
        .even_clk  (even_clk),
        .odd_clk   (odd_clk),
        .cfg       (cfg),
        .clk_out   (clk_out)
    );

    clkdiv_even clkdiv_even_i (
        .clk      (clk),
        .resetb   (resetb),
        .cfg      (cfg),
        .even_clk (even_clk)
    );

    clkdiv_odd clkdiv_odd_i (
        .clk     (clk),
        .resetb  (resetb),
        .cfg     (cfg),
        .odd_clk (odd_clk)
    );

    // watches the selected output, whatever the mode
    clkdiv_monitor clkdiv_monitor_i (
        .clk     (clk),
        .resetb  (resetb),
        .clk_out (clk_out),
        .stat    (stat)
    );

endmodule

// File: tb/tb_clock.sv
// Testbench clock and reset
module tb_clock (
    output logic clk,
    output logic resetb
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_NS      = 10;    // 20 ns period
    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_NS) clk = ~clk;
        end
    end

    // reset drops at time zero, released on a rising edge
    initial begin
        resetb = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        resetb <= 1'b1;
    end

endmodule

// File: tb/tb_clkdiv.sv
// Clock divider testbench
module tb_clkdiv;
    timeunit 1ns;
    timeprecision 1ps;

    import clkdiv_pkg::*;

    localparam logic [31:0] SEED   = 32'hcb9ef01c;
    localparam int CLK_NS          = 20;
    localparam int SETTLE          = 120;   // clk cycles from a write to a steady output
    localparam int MEASURE         = 200;   // clk cycles spent checking one divisor, worst case
    localparam int REPORT_TIMEOUT  = 64;    // clk cycles to wait for one stat.valid
    localparam int SAMPLES         = 3;     // periods and high times per divisor
    localparam int N_EVEN          = 6;
    localparam int N_ODD           = 6;
    localparam int N_BYPASS        = 2;
    localparam int N_BURST         = 6;     // odd even odd, fast then settled
    localparam int BURST_GAP       = 20;    // lands mid resync on slow outputs
    localparam int N_WRITES = 1 + N_EVEN + N_ODD + N_BYPASS + N_BURST;   // reset counts as one

    logic             clk;
    logic             resetb;
    logic             div_wr;
    logic [DIV_W-1:0] div_value;
    logic             clk_out;
    div_stat_t        stat;
    logic [31:0]      rng;                  // xorshift state
    logic [DIV_W-1:0] burst_div [3];

    tb_clock tb_clock_i (
        .clk    (clk),
        .resetb (resetb)
    );

    clkdiv_top clkdiv_top_i (
        .clk       (clk),
        .resetb    (resetb),
        .div_wr    (div_wr),
        .div_value (div_value),
        .clk_out   (clk_out),
        .stat      (stat)
    );

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // 2..14 and 3..15
    function automatic logic [DIV_W-1:0] even_divisor(input logic [31:0] r);
        return DIV_W'(32'd2 + 32'd2 * (r % 32'd7));
    endfunction

    function automatic logic [DIV_W-1:0] odd_divisor(input logic [31:0] r);
        return DIV_W'(32'd3 + 32'd2 * (r % 32'd7));
    endfunction

    // model: one report per output period of N input cycles
    function automatic div_stat_t expected_stat(input logic [DIV_W-1:0] n);
        div_stat_t s;
        s.valid  = 1'b1;
        s.period = PER_W'(n);
        return s;
    endfunction

    task automatic abort_run();
        $display("test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_stat(input string name, input div_stat_t exp, input div_stat_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected valid %b period %0d, actual valid %b period %0d",
                     $time, name, exp.valid, exp.period, act.valid, act.period);
            abort_run();
        end
    endtask

    task automatic check_high(input string name, input time exp, input time act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %0d ns actual %0d ns", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %b actual %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    // one strobe on div_wr, value held for that cycle only
    task automatic write_div(input logic [DIV_W-1:0] n);
        @(posedge clk);
        div_wr    <= 1'b1;
        div_value <= n;
        @(posedge clk);
        div_wr    <= 1'b0;
    endtask

    task automatic settle();
        repeat (SETTLE) @(posedge clk);
    endtask

    // stat is registered on the rising edge, looked at on the falling one
    task automatic wait_report(output div_stat_t s);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!stat.valid) begin
            if (waited == REPORT_TIMEOUT) begin
                $display("no period report from the monitor within %0d cycles", REPORT_TIMEOUT);
                abort_run();
            end else begin
                waited++;
                @(negedge clk);
            end
        end
        s = stat;
    endtask

    task automatic measure_high(output time t);
        time t_rise;
        @(posedge clk_out);
        t_rise = $time;
        @(negedge clk_out);
        t = $time - t_rise;
    endtask

    // periods from the monitor, then high times from edge stamps
    task automatic check_divisor(input logic [DIV_W-1:0] n);
        div_stat_t s;
        time       t;
        for (int i = 0; i < SAMPLES; i++) begin
            wait_report(s);
            check_stat("stat", expected_stat(n), s);
        end
        for (int i = 0; i < SAMPLES; i++) begin
            measure_high(t);
            check_high("clk_out high time", 64'(n) * 64'(CLK_NS / 2), t);    // N half periods
        end
    endtask

    // clk_out is clk itself, and the monitor stays quiet
    task automatic check_bypass();
        repeat (16) begin
            @(posedge clk);
            #5;
            check_bit("clk_out", 1'b1, clk_out);
            @(negedge clk);
            #5;
            check_bit("clk_out", 1'b0, clk_out);
            check_bit("stat.valid", 1'b0, stat.valid);
        end
    endtask

    // watchdog
    initial begin
        #(longint'(N_WRITES) * (SETTLE + MEASURE) * CLK_NS * 2);
        $display("timeout, the run did not finish within the expected time");
        abort_run();
    end

    initial begin
        logic [DIV_W-1:0] n;
        div_wr    = 1'b0;
        div_value = '0;
        rng       = SEED;
        @(posedge resetb);

        // reset divisor, no write
        settle();
        check_divisor(DIV_RESET);

        for (int i = 0; i < N_EVEN; i++) begin
            rng = next_rand(rng);
            n   = even_divisor(rng);
            write_div(n);
            settle();
            check_divisor(n);
        end

        for (int i = 0; i < N_ODD; i++) begin
            rng = next_rand(rng);
            n   = odd_divisor(rng);
            write_div(n);
            settle();
            check_divisor(n);
        end

        // divide by 0 then by 1
        for (int i = 0; i < N_BYPASS; i++) begin
            write_div(DIV_W'(i));
            settle();
            check_bypass();
        end

        // odd even odd, each write lands before the last has settled
        rng          = next_rand(rng);
        burst_div[0] = odd_divisor(rng);
        rng          = next_rand(rng);
        burst_div[1] = even_divisor(rng);
        rng          = next_rand(rng);
        burst_div[2] = odd_divisor(rng);
        for (int i = 0; i < 3; i++) begin
            write_div(burst_div[i]);
            repeat (BURST_GAP) @(posedge clk);
        end
        settle();
        check_divisor(burst_div[2]);

        // same chain again, settled and checked at every step
        for (int i = 0; i < 3; i++) begin
            write_div(burst_div[i]);
            settle();
            check_divisor(burst_div[i]);
        end

        $display("test passed");
        $finish;
    end

endmodule

// File: sources.f
src/clkdiv_pkg.sv
src/clkdiv_ctrl.sv
src/clkdiv_even.sv
src/clkdiv_odd.sv
src/clkdiv_monitor.sv
src/clkdiv_top.sv
tb/tb_clock.sv
tb/tb_clkdiv.sv

// File: Makefile
# Verilator flow for the clock divider

TOP := tb_clkdiv

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f sources.f

# the run passes only if the pass line shows up in the output
run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qxF "test passed"

lint:
	verilator --lint-only -Wall --timing --top-module clkdiv_top -f sources.f

clean:
	rm -rf obj_dir
